//--- rtl/tinkerPkg.sv
// Tinker core shared definitions
// Widths, memory map, opcode and sequencer state encodings, decoded instruction

package tinkerPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and memory map
  ////////////////////////////////////////////////////////////////////////////
  localparam int XLEN        = 64;                 // Data and address width
  localparam int INSTR_W     = 32;                 // Instruction word width
  localparam int REG_ADDR_W  = 5;                  // Register index width
  localparam int NUM_REGS    = 32;
  localparam int STACK_REG   = 31;                 // Stack base register
  localparam int MEM_BYTES   = 16384;              // Unified memory size
  localparam int MEM_ADDR_W  = $clog2(MEM_BYTES);  // Addresses wrap at this width
  localparam logic [XLEN-1:0] STACK_BASE  = XLEN'(MEM_BYTES); // Top of memory
  localparam logic [XLEN-1:0] RESET_PC    = 64'h2000;
  localparam logic [XLEN-1:0] INSTR_BYTES = 64'd4;            // PC step

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [4:0] {
    OP_AND     = 5'b00000,
    OP_OR      = 5'b00001,
    OP_XOR     = 5'b00010,
    OP_NOT     = 5'b00011,
    OP_SHFTR   = 5'b00100,
    OP_SHFTRI  = 5'b00101,
    OP_SHFTL   = 5'b00110,
    OP_SHFTLI  = 5'b00111,
    OP_BR      = 5'b01000,  // Jump to rd
    OP_BRR_REG = 5'b01001,  // PC relative by rd
    OP_BRR_LIT = 5'b01010,  // PC relative by signed literal
    OP_BRNZ    = 5'b01011,
    OP_BRGT    = 5'b01110,
    OP_HLT     = 5'b01111,
    OP_LOAD    = 5'b10000,  // rd <= mem[rs + L]
    OP_MOV_REG = 5'b10001,
    OP_MOV_LIT = 5'b10010,  // Replaces low 12 bits of rd
    OP_STORE   = 5'b10011,  // mem[rd + L] <= rs
    OP_ADD     = 5'b11000,
    OP_ADDI    = 5'b11001,
    OP_SUB     = 5'b11010,
    OP_SUBI    = 5'b11011,
    OP_MUL     = 5'b11100
  } opcode_t;

  typedef enum logic [2:0] {
    FETCH      = 3'd0,
    DECODE     = 3'd1,
    EXECUTE    = 3'd2,
    MEM_ACCESS = 3'd3,
    WRITE_BACK = 3'd4
  } ctrlState_t;

  typedef struct packed {
    opcode_t                opcode;
    logic [REG_ADDR_W-1:0]  rd;
    logic [REG_ADDR_W-1:0]  rs;      // Already swapped to rd on immediate ops
    logic [REG_ADDR_W-1:0]  rt;
    logic [XLEN-1:0]        imm;     // Zero extended literal
    logic                   useImm;  // Operand B comes from imm
    logic                   isLoad;
    logic                   isStore;
    logic                   isBranch;
  } decodedInstr_t;

endpackage

//--- rtl/coreCtrlIf.sv
// Sequencer control bundle
// Per-state enables and the current state, fanned out to the datapath

`timescale 1ns/1ps

interface coreCtrlIf;

  logic                  regWrite;  // Register write, WRITE_BACK only
  logic                  memRead;   // Load data read, MEM_ACCESS only
  logic                  memWrite;  // Store commit, MEM_ACCESS only
  logic                  pcWrite;   // Last state of every instruction
  tinkerPkg::ctrlState_t state;

  modport ctrl    (output regWrite, memRead, memWrite, pcWrite, state);
  modport pcPort  (input pcWrite);
  modport regPort (input regWrite);
  modport memPort (input memRead, memWrite, state);

endinterface

//--- rtl/dataMemIf.sv
// Data access bundle between execute unit and unified memory
// Address and write data from the requester, read data back combinationally

`timescale 1ns/1ps

interface dataMemIf;

  logic [tinkerPkg::XLEN-1:0] addr;   // Byte address, wraps in memory
  logic [tinkerPkg::XLEN-1:0] wdata;  // Store data
  logic [tinkerPkg::XLEN-1:0] rdata;  // Load data, little endian

  modport requester (output addr, wdata, input rdata);
  modport memory    (input addr, wdata, output rdata);

endinterface

//--- rtl/cycleControl.sv
// Five-state instruction sequencer
// FETCH, DECODE, EXECUTE, then MEM_ACCESS and/or WRITE_BACK by class.
// Raises each enable only in its own state and parks in EXECUTE on hlt.

`timescale 1ns/1ps

module cycleControl (
  input  logic                     clk,
  input  logic                     reset,
  input  tinkerPkg::decodedInstr_t instr,
  coreCtrlIf.ctrl                  ctl,
  output logic                     hlt
);

  tinkerPkg::ctrlState_t state;
  tinkerPkg::ctrlState_t nextState;
  logic                  isHalt;

  assign isHalt = (instr.opcode == tinkerPkg::OP_HLT);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= tinkerPkg::FETCH;
    end else begin
      state <= nextState;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nextState = tinkerPkg::FETCH;
    case (state)
      tinkerPkg::FETCH:  nextState = tinkerPkg::DECODE;
      tinkerPkg::DECODE: nextState = tinkerPkg::EXECUTE;
      tinkerPkg::EXECUTE: begin
        if (isHalt) begin
          nextState = tinkerPkg::EXECUTE;              // Parked until reset
        end else if (instr.isBranch) begin
          nextState = tinkerPkg::FETCH;                // PC already loaded
        end else if (instr.isLoad || instr.isStore) begin
          nextState = tinkerPkg::MEM_ACCESS;
        end else begin
          nextState = tinkerPkg::WRITE_BACK;
        end
      end
      tinkerPkg::MEM_ACCESS: begin
        nextState = instr.isLoad ? tinkerPkg::WRITE_BACK : tinkerPkg::FETCH;
      end
      default: nextState = tinkerPkg::FETCH;           // WRITE_BACK and unused codes
    endcase
  end

  // Enables are pure decodes of the state
  assign ctl.state    = state;
  assign ctl.regWrite = (state == tinkerPkg::WRITE_BACK);
  assign ctl.memRead  = (state == tinkerPkg::MEM_ACCESS) && instr.isLoad;
  assign ctl.memWrite = (state == tinkerPkg::MEM_ACCESS) && instr.isStore;
  assign ctl.pcWrite  = (state == tinkerPkg::WRITE_BACK)
                      || ((state == tinkerPkg::MEM_ACCESS) && instr.isStore)
                      || ((state == tinkerPkg::EXECUTE) && instr.isBranch);
  assign hlt          = (state == tinkerPkg::EXECUTE) && isHalt;

  // One data access direction per cycle
  assert property (@(posedge clk) disable iff (reset) !(ctl.memRead && ctl.memWrite));

  // Halt is sticky, relies on PC and fetched word staying put
  assert property (@(posedge clk) disable iff (reset) hlt |=> hlt);

endmodule

//--- rtl/instrDecoder.sv
// Instruction decoder
// Field split, rd-as-source swap for immediate ops, operand-select and class flags

`timescale 1ns/1ps

module instrDecoder (
  input  logic [tinkerPkg::INSTR_W-1:0] word,
  output tinkerPkg::decodedInstr_t      instr
);

  tinkerPkg::opcode_t rawOp;

  always_comb begin
    rawOp = tinkerPkg::opcode_t'(word[31:27]);
    case (rawOp)
      tinkerPkg::OP_AND, tinkerPkg::OP_OR, tinkerPkg::OP_XOR, tinkerPkg::OP_NOT,
      tinkerPkg::OP_SHFTR, tinkerPkg::OP_SHFTRI, tinkerPkg::OP_SHFTL, tinkerPkg::OP_SHFTLI,
      tinkerPkg::OP_BR, tinkerPkg::OP_BRR_REG, tinkerPkg::OP_BRR_LIT, tinkerPkg::OP_BRNZ,
      tinkerPkg::OP_BRGT, tinkerPkg::OP_HLT, tinkerPkg::OP_LOAD, tinkerPkg::OP_MOV_REG,
      tinkerPkg::OP_MOV_LIT, tinkerPkg::OP_STORE, tinkerPkg::OP_ADD, tinkerPkg::OP_ADDI,
      tinkerPkg::OP_SUB, tinkerPkg::OP_SUBI, tinkerPkg::OP_MUL: instr.opcode = rawOp;
      default: instr.opcode = tinkerPkg::OP_AND;       // Unknown behaves as and
    endcase

    instr.rd  = word[26:22];
    instr.rs  = word[21:17];
    instr.rt  = word[16:12];
    instr.imm = {{(tinkerPkg::XLEN-12){1'b0}}, word[11:0]};

    case (instr.opcode)                                // rd doubles as source
      tinkerPkg::OP_ADDI, tinkerPkg::OP_SUBI, tinkerPkg::OP_SHFTRI,
      tinkerPkg::OP_SHFTLI, tinkerPkg::OP_MOV_LIT: instr.rs = word[26:22];
      default: ;
    endcase

    instr.isLoad   = (instr.opcode == tinkerPkg::OP_LOAD);
    instr.isStore  = (instr.opcode == tinkerPkg::OP_STORE);
    instr.isBranch = instr.opcode inside {tinkerPkg::OP_BR, tinkerPkg::OP_BRR_REG,
                                          tinkerPkg::OP_BRR_LIT, tinkerPkg::OP_BRNZ,
                                          tinkerPkg::OP_BRGT};
    instr.useImm   = instr.isLoad || instr.isStore
                   || instr.opcode inside {tinkerPkg::OP_ADDI, tinkerPkg::OP_SUBI,
                                           tinkerPkg::OP_SHFTRI, tinkerPkg::OP_SHFTLI,
                                           tinkerPkg::OP_MOV_LIT};
  end

endmodule

//--- rtl/regFile.sv
// 32 x 64-bit register file
// Three combinational reads, one write at WRITE_BACK, r31 resets to stack base

`timescale 1ns/1ps

module regFile (
  input  logic                             clk,
  input  logic                             reset,
  coreCtrlIf.regPort                       ctl,
  input  logic [tinkerPkg::REG_ADDR_W-1:0] rdAddr,  // Also the write index
  input  logic [tinkerPkg::REG_ADDR_W-1:0] rsAddr,
  input  logic [tinkerPkg::REG_ADDR_W-1:0] rtAddr,
  input  logic [tinkerPkg::XLEN-1:0]       wdata,
  output logic [tinkerPkg::XLEN-1:0]       rdVal,
  output logic [tinkerPkg::XLEN-1:0]       rsVal,
  output logic [tinkerPkg::XLEN-1:0]       rtVal
);

  logic [tinkerPkg::XLEN-1:0] regs [tinkerPkg::NUM_REGS];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < tinkerPkg::NUM_REGS; i++) begin
        regs[i] <= (i == tinkerPkg::STACK_REG) ? tinkerPkg::STACK_BASE : '0;
      end
    end else if (ctl.regWrite) begin
      regs[rdAddr] <= wdata;                           // r0 is writable
    end
  end

  assign rdVal = regs[rdAddr];  // Store base, branch target, mov literal upper bits
  assign rsVal = regs[rsAddr];
  assign rtVal = regs[rtAddr];

endmodule

//--- rtl/execUnit.sv
// Integer execute unit
// Operand B select, ALU, load/store address and store data, write-back select

`timescale 1ns/1ps

module execUnit (
  input  tinkerPkg::decodedInstr_t   instr,
  input  logic [tinkerPkg::XLEN-1:0] rdVal,
  input  logic [tinkerPkg::XLEN-1:0] rsVal,
  input  logic [tinkerPkg::XLEN-1:0] rtVal,
  dataMemIf.requester                mem,
  output logic [tinkerPkg::XLEN-1:0] wbData
);

  logic [tinkerPkg::XLEN-1:0] opB;
  logic [tinkerPkg::XLEN-1:0] aluResult;

  assign opB = instr.useImm ? instr.imm : rtVal;

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (instr.opcode)
      tinkerPkg::OP_ADD, tinkerPkg::OP_ADDI:     aluResult = rsVal + opB;
      tinkerPkg::OP_SUB, tinkerPkg::OP_SUBI:     aluResult = rsVal - opB;
      tinkerPkg::OP_MUL:                         aluResult = rsVal * opB;  // Low 64 bits
      tinkerPkg::OP_AND:                         aluResult = rsVal & opB;
      tinkerPkg::OP_OR:                          aluResult = rsVal | opB;
      tinkerPkg::OP_XOR:                         aluResult = rsVal ^ opB;
      tinkerPkg::OP_NOT:                         aluResult = ~rsVal;
      tinkerPkg::OP_SHFTR, tinkerPkg::OP_SHFTRI: aluResult = rsVal >> opB;  // Logical
      tinkerPkg::OP_SHFTL, tinkerPkg::OP_SHFTLI: aluResult = rsVal << opB;
      tinkerPkg::OP_MOV_REG:                     aluResult = rsVal;
      tinkerPkg::OP_MOV_LIT:                     aluResult = {rdVal[63:12], instr.imm[11:0]};
      default:                                   aluResult = '0;  // Branches, memory, hlt
    endcase
  end

  // Load base is rs, store base is rd
  assign mem.addr  = (instr.isStore ? rdVal : rsVal) + instr.imm;
  assign mem.wdata = rsVal;

  // Loaded word stays valid through WRITE_BACK
  assign wbData = instr.isLoad ? mem.rdata : aluResult;

endmodule

//--- rtl/pcUnit.sv
// Program counter
// Branch resolution and next-PC, loaded in the last state of each instruction

`timescale 1ns/1ps

module pcUnit (
  input  logic                       clk,
  input  logic                       reset,
  coreCtrlIf.pcPort                  ctl,
  input  tinkerPkg::decodedInstr_t   instr,
  input  logic [tinkerPkg::XLEN-1:0] rdVal,  // Branch target or offset
  input  logic [tinkerPkg::XLEN-1:0] rsVal,  // brnz test, brgt left side
  input  logic [tinkerPkg::XLEN-1:0] rtVal,  // brgt right side
  output logic [tinkerPkg::XLEN-1:0] pc
);

  logic [tinkerPkg::XLEN-1:0] pcNext;
  logic [tinkerPkg::XLEN-1:0] immSext;

  assign immSext = {{(tinkerPkg::XLEN-12){instr.imm[11]}}, instr.imm[11:0]};

  always_comb begin
    pcNext = pc + tinkerPkg::INSTR_BYTES;              // Fall through
    case (instr.opcode)
      tinkerPkg::OP_BR:      pcNext = rdVal;
      tinkerPkg::OP_BRR_REG: pcNext = pc + rdVal;
      tinkerPkg::OP_BRR_LIT: pcNext = pc + immSext;
      tinkerPkg::OP_BRNZ:    if (rsVal != '0) pcNext = rdVal;
      tinkerPkg::OP_BRGT:    if ($signed(rsVal) > $signed(rtVal)) pcNext = rdVal;
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= tinkerPkg::RESET_PC;
    end else if (ctl.pcWrite) begin
      pc <= pcNext;
    end
  end

endmodule

//--- rtl/byteMemory.sv
// Unified little-endian byte memory
// Combinational 4-byte fetch and 8-byte data read, 8-byte store, 4-byte program load.
// Addresses wrap at the memory size.

`timescale 1ns/1ps

module byteMemory (
  input  logic                          clk,
  coreCtrlIf.memPort                    ctl,
  dataMemIf.memory                      mem,
  input  logic [tinkerPkg::XLEN-1:0]    instrAddr,
  output logic [tinkerPkg::INSTR_W-1:0] word,
  input  logic                          progWrite,
  input  logic [tinkerPkg::XLEN-1:0]    progAddr,
  input  logic [tinkerPkg::INSTR_W-1:0] progData,
  output logic                          storeValid,
  output logic [tinkerPkg::XLEN-1:0]    storeAddr,
  output logic [tinkerPkg::XLEN-1:0]    storeData
);

  logic [7:0]                 memArray [tinkerPkg::MEM_BYTES];
  logic [tinkerPkg::XLEN-1:0] dataBytes;  // Raw read at mem.addr
  logic [tinkerPkg::XLEN-1:0] loadHold;   // Load value kept for WRITE_BACK

  // Byte index of base plus offset, wrapped
  function automatic logic [tinkerPkg::MEM_ADDR_W-1:0] byteIdx(
    input logic [tinkerPkg::XLEN-1:0] base,
    input logic [2:0]                 offset
  );
    return base[tinkerPkg::MEM_ADDR_W-1:0] + {{(tinkerPkg::MEM_ADDR_W-3){1'b0}}, offset};
  endfunction

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      word[8*i +: 8] = memArray[byteIdx(instrAddr, 3'(i))];
    end
    for (int i = 0; i < 8; i++) begin
      dataBytes[8*i +: 8] = memArray[byteIdx(mem.addr, 3'(i))];
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.memWrite) begin
      for (int i = 0; i < 8; i++) begin
        memArray[byteIdx(mem.addr, 3'(i))] <= mem.wdata[8*i +: 8];
      end
    end
    if (progWrite) begin
      for (int i = 0; i < 4; i++) begin
        memArray[byteIdx(progAddr, 3'(i))] <= progData[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.memRead) loadHold <= dataBytes;
  end

  assign mem.rdata = ctl.memRead ? dataBytes : loadHold;

  // Store monitor taps the write port directly
  assign storeValid = ctl.memWrite;
  assign storeAddr  = mem.addr;
  assign storeData  = mem.wdata;

  // Program load only while the core is idle in reset
  assert property (@(posedge clk) !(progWrite && ctl.memWrite));

endmodule

//--- rtl/tinkerCore.sv
// Tinker multi-cycle 64-bit core
// Sequencer, decoder, register file, execute, PC and unified memory.
// Program load port and store monitor port are plain signals.

`timescale 1ns/1ps

module tinkerCore (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          progWrite,  // Word write, used during reset
  input  logic [tinkerPkg::XLEN-1:0]    progAddr,
  input  logic [tinkerPkg::INSTR_W-1:0] progData,
  output logic                          storeValid, // Store committing this cycle
  output logic [tinkerPkg::XLEN-1:0]    storeAddr,
  output logic [tinkerPkg::XLEN-1:0]    storeData,
  output logic                          hlt
);

  coreCtrlIf ctlBus ();
  dataMemIf  dataBus ();

  logic [tinkerPkg::XLEN-1:0]    pc;
  logic [tinkerPkg::INSTR_W-1:0] word;     // Fetched at pc
  tinkerPkg::decodedInstr_t      instr;
  logic [tinkerPkg::XLEN-1:0]    rdVal;
  logic [tinkerPkg::XLEN-1:0]    rsVal;
  logic [tinkerPkg::XLEN-1:0]    rtVal;
  logic [tinkerPkg::XLEN-1:0]    wbData;   // Register write-back value

  cycleControl cycleCtrl (
    .clk(clk), .reset(reset), .instr(instr), .ctl(ctlBus.ctrl), .hlt(hlt)
  );

  instrDecoder decoder (.word(word), .instr(instr));

  regFile regBank (
    .clk(clk), .reset(reset), .ctl(ctlBus.regPort),
    .rdAddr(instr.rd), .rsAddr(instr.rs), .rtAddr(instr.rt),
    .wdata(wbData), .rdVal(rdVal), .rsVal(rsVal), .rtVal(rtVal)
  );

  execUnit execute (
    .instr(instr), .rdVal(rdVal), .rsVal(rsVal), .rtVal(rtVal),
    .mem(dataBus.requester), .wbData(wbData)
  );

  pcUnit pcLogic (
    .clk(clk), .reset(reset), .ctl(ctlBus.pcPort), .instr(instr),
    .rdVal(rdVal), .rsVal(rsVal), .rtVal(rtVal), .pc(pc)
  );

  byteMemory mainMem (
    .clk(clk), .ctl(ctlBus.memPort), .mem(dataBus.memory),
    .instrAddr(pc), .word(word),
    .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
    .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
  );

endmodule

//--- dv/tinkerModel.svh
// Tinker core instruction-level model and random program builder
// Builds test programs as word queues and predicts every committed store

`ifndef TINKER_MODEL_SVH
`define TINKER_MODEL_SVH

logic [31:0] progWords[$];   // Program image, placed at RESET_PC
logic [63:0] expAddr[$];     // Predicted store addresses, in commit order
logic [63:0] expData[$];
logic [7:0]  refMem[int];    // Model memory, keyed by wrapped byte address

tinkerPkg::opcode_t immOps[5] = '{tinkerPkg::OP_ADDI, tinkerPkg::OP_SUBI, tinkerPkg::OP_SHFTRI,
                                  tinkerPkg::OP_SHFTLI, tinkerPkg::OP_MOV_LIT};
tinkerPkg::opcode_t regOps[10] = '{tinkerPkg::OP_ADD, tinkerPkg::OP_SUB, tinkerPkg::OP_MUL,
                                   tinkerPkg::OP_AND, tinkerPkg::OP_OR, tinkerPkg::OP_XOR,
                                   tinkerPkg::OP_NOT, tinkerPkg::OP_SHFTR, tinkerPkg::OP_SHFTL,
                                   tinkerPkg::OP_MOV_REG};
tinkerPkg::opcode_t brOps[5] = '{tinkerPkg::OP_BR, tinkerPkg::OP_BRR_REG, tinkerPkg::OP_BRR_LIT,
                                 tinkerPkg::OP_BRNZ, tinkerPkg::OP_BRGT};

// Opcode, rd, rs, rt, 12-bit literal, high to low
function automatic void emit(tinkerPkg::opcode_t op, int rd, int rs, int rt, int lit);
  progWords.push_back({op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)});
endfunction

// Clear, then build a 36-bit value 12 bits at a time
function automatic void loadRegister(int r, logic [35:0] v);
  emit(tinkerPkg::OP_XOR, r, r, r, 0);
  emit(tinkerPkg::OP_MOV_LIT, r, 0, 0, int'(v[35:24]));
  emit(tinkerPkg::OP_SHFTLI, r, 0, 0, 12);
  emit(tinkerPkg::OP_MOV_LIT, r, 0, 0, int'(v[23:12]));
  emit(tinkerPkg::OP_SHFTLI, r, 0, 0, 12);
  emit(tinkerPkg::OP_MOV_LIT, r, 0, 0, int'(v[11:0]));
endfunction

function automatic int memIdx(logic [63:0] addr);
  return int'(addr[tinkerPkg::MEM_ADDR_W-1:0]);  // Low address bits only, wraps
endfunction

function automatic logic [63:0] readBytes(logic [63:0] addr, int n);
  logic [63:0] v;
  int          k;
  v = '0;
  for (int i = 0; i < n; i++) begin
    k = memIdx(addr + 64'(i));
    v[8*i +: 8] = refMem.exists(k) ? refMem[k] : 8'h00;  // Little endian
  end
  return v;
endfunction

function automatic void writeBytes(logic [63:0] addr, logic [63:0] data, int n);
  for (int i = 0; i < n; i++) begin
    refMem[memIdx(addr + 64'(i))] = data[8*i +: 8];
  end
endfunction

////////////////////////////////////////////////////////////////////////////
// Reference execution, one instruction per iteration
////////////////////////////////////////////////////////////////////////////
function automatic void runModel();
  logic [63:0]        r[32];
  logic [63:0]        pc;
  logic [63:0]        nextPc;
  logic [63:0]        lit;
  logic [63:0]        opB;
  logic [31:0]        w;
  tinkerPkg::opcode_t op;
  int                 rd;
  int                 rs;
  int                 rt;
  refMem.delete();
  expAddr.delete();
  expData.delete();
  foreach (progWords[i]) writeBytes(tinkerPkg::RESET_PC + 64'(4 * i), 64'(progWords[i]), 4);
  foreach (r[i]) r[i] = '0;
  r[tinkerPkg::STACK_REG] = tinkerPkg::STACK_BASE;  // Stack base survives reset
  pc = tinkerPkg::RESET_PC;
  for (int n = 0; n < 200; n++) begin
    w   = 32'(readBytes(pc, 4));
    op  = tinkerPkg::opcode_t'(w[31:27]);
    rd  = int'(w[26:22]);
    rs  = int'(w[21:17]);
    rt  = int'(w[16:12]);
    lit = 64'(w[11:0]);                              // Zero extended
    if (op inside {immOps}) rs = rd;                 // Immediate forms read rd
    opB    = (op inside {immOps}) ? lit : r[rt];
    nextPc = pc + 64'd4;
    case (op)
      tinkerPkg::OP_ADD, tinkerPkg::OP_ADDI:     r[rd] = r[rs] + opB;
      tinkerPkg::OP_SUB, tinkerPkg::OP_SUBI:     r[rd] = r[rs] - opB;
      tinkerPkg::OP_MUL:                         r[rd] = r[rs] * opB;
      tinkerPkg::OP_AND:                         r[rd] = r[rs] & opB;
      tinkerPkg::OP_OR:                          r[rd] = r[rs] | opB;
      tinkerPkg::OP_XOR:                         r[rd] = r[rs] ^ opB;
      tinkerPkg::OP_NOT:                         r[rd] = ~r[rs];
      tinkerPkg::OP_SHFTR, tinkerPkg::OP_SHFTRI: r[rd] = r[rs] >> opB;
      tinkerPkg::OP_SHFTL, tinkerPkg::OP_SHFTLI: r[rd] = r[rs] << opB;
      tinkerPkg::OP_MOV_REG:                     r[rd] = r[rs];
      tinkerPkg::OP_MOV_LIT:                     r[rd] = {r[rd][63:12], w[11:0]};
      tinkerPkg::OP_LOAD:                        r[rd] = readBytes(r[rs] + lit, 8);
      tinkerPkg::OP_STORE: begin
        expAddr.push_back(r[rd] + lit);
        expData.push_back(r[rs]);
        writeBytes(r[rd] + lit, r[rs], 8);
      end
      tinkerPkg::OP_BR:      nextPc = r[rd];
      tinkerPkg::OP_BRR_REG: nextPc = pc + r[rd];
      tinkerPkg::OP_BRR_LIT: nextPc = pc + {{52{w[11]}}, w[11:0]};
      tinkerPkg::OP_BRNZ:    if (r[rs] != '0) nextPc = r[rd];
      tinkerPkg::OP_BRGT:    if ($signed(r[rs]) > $signed(r[rt])) nextPc = r[rd];
      tinkerPkg::OP_HLT:     return;
      default: ;
    endcase
    pc = nextPc;
  end
endfunction

`endif

//--- dv/tbTinkerCore.sv
// Testbench for the Tinker multi-cycle core
// Random programs run on the DUT and on an instruction-level model.
// Committed stores and the halt level are compared per test.

`timescale 1ns/1ps

module tbTinkerCore;

  localparam int NUM_TESTS  = 6;
  localparam int MAX_INSTRS = 200;

  logic                          clk;
  logic                          reset;
  logic                          progWrite;
  logic [tinkerPkg::XLEN-1:0]    progAddr;
  logic [tinkerPkg::INSTR_W-1:0] progData;
  logic                          storeValid;
  logic [tinkerPkg::XLEN-1:0]    storeAddr;
  logic [tinkerPkg::XLEN-1:0]    storeData;
  logic                          hlt;

  logic [63:0] gotAddr[$];   // Stores seen on the monitor port
  logic [63:0] gotData[$];
  int          errors;       // Failed checks over the run
  int          testErrors;
  int          failedTests;

  `include "tinkerModel.svh"

  tinkerCore tinkerCore_inst (
    .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
    .progData(progData), .storeValid(storeValid), .storeAddr(storeAddr),
    .storeData(storeData), .hlt(hlt)
  );

  always #5 clk = ~clk;

  always @(negedge clk) begin                        // Sampled away from the drive edge
    if (!reset && storeValid) begin
      gotAddr.push_back(storeAddr);
      gotData.push_back(storeData);
    end
  end

  task automatic checkStore(int idx, logic [tinkerPkg::XLEN-1:0] gotA,
                            logic [tinkerPkg::XLEN-1:0] gotD,
                            logic [tinkerPkg::XLEN-1:0] expA,
                            logic [tinkerPkg::XLEN-1:0] expD);
    if (gotA !== expA) begin
      $display("FAIL storeAddr[%0d]: got 0x%h expected 0x%h", idx, gotA, expA);
      testErrors++;
    end
    if (gotD !== expD) begin
      $display("FAIL storeData[%0d]: got 0x%h expected 0x%h", idx, gotD, expD);
      testErrors++;
    end
  endtask

  task automatic checkHalt(logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL hlt: got 0x%h expected 0x%h", got, exp);
      testErrors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Program builders
  ////////////////////////////////////////////////////////////////////////////
  function automatic void randomAluProgram(bit immOnly);
    tinkerPkg::opcode_t op;
    progWords.delete();
    for (int r = 1; r <= 8; r++) loadRegister(r, 36'({$urandom(), $urandom()}));
    for (int i = 0; i < 30; i++) begin
      op = (immOnly || $urandom_range(1, 0) == 0) ? immOps[$urandom_range(4, 0)]
                                                  : regOps[$urandom_range(9, 0)];
      emit(op, $urandom_range(8, 1), $urandom_range(8, 0), $urandom_range(8, 0),
           (op inside {tinkerPkg::OP_SHFTRI, tinkerPkg::OP_SHFTLI}) ?
           $urandom_range(63, 0) : $urandom_range(4095, 0));
    end
    for (int i = 0; i < 32; i++) emit(tinkerPkg::OP_STORE, 0, i, 0, 8 * i);  // r0 stays 0
    emit(tinkerPkg::OP_HLT, 0, 0, 0, 0);
  endfunction

  function automatic void memoryRoundTrip();
    int off[4];
    progWords.delete();
    loadRegister(9, 36'(8 * $urandom_range(511, 0)));           // Store and load base
    for (int i = 0; i < 4; i++) begin
      loadRegister(i + 1, 36'({$urandom(), $urandom()}));
      off[i] = 8 * (64 * i + $urandom_range(63, 0));             // Disjoint slots
      emit(tinkerPkg::OP_STORE, 9, i + 1, 0, off[i]);
    end
    for (int i = 0; i < 4; i++) emit(tinkerPkg::OP_LOAD, 10 + i, 9, 0, off[i]);
    for (int i = 0; i < 4; i++) emit(tinkerPkg::OP_STORE, 0, 10 + i, 0, 'h800 + 8 * i);
    emit(tinkerPkg::OP_HLT, 0, 0, 0, 0);
  endfunction

  // Each block branches over one marker store when taken.
  // Blocks 0 to 4 take their branch, blocks 5 to 7 fall through.
  function automatic void branchMix();
    tinkerPkg::opcode_t op;
    bit                 taken;
    int                 skip;
    int                 at;
    progWords.delete();
    for (int i = 0; i < 8; i++) begin
      op    = brOps[4 - i % 5];                      // brgt, brnz, brr literal come twice
      taken = (i < 5);
      skip  = taken ? 8 : 4;
      loadRegister(21, 36'($urandom()));
      if (!taken) emit(tinkerPkg::OP_NOT, 21, 21, 0, 0);  // Negative
      if (!taken && op == tinkerPkg::OP_BRNZ) begin
        emit(tinkerPkg::OP_XOR, 21, 21, 21, 0);           // Zero
      end
      loadRegister(22, 36'($urandom()));
      if (taken) emit(tinkerPkg::OP_NOT, 22, 22, 0, 0);   // Below a positive r21
      at = progWords.size() + 8;                     // Second marker store
      if (op == tinkerPkg::OP_BRR_REG) loadRegister(20, 36'(skip));
      else loadRegister(20, 36'(tinkerPkg::RESET_PC + 64'(4 * at)));
      emit(op, 20, 21, 22, skip);
      emit(tinkerPkg::OP_STORE, 0, 21, 0, 16 * i);
      emit(tinkerPkg::OP_STORE, 0, 22, 0, 16 * i + 8);
    end
    emit(tinkerPkg::OP_HLT, 0, 0, 0, 0);
  endfunction

  function automatic void haltProgram();
    progWords.delete();
    loadRegister(1, 36'({$urandom(), $urandom()}));
    emit(tinkerPkg::OP_NOT, 0, 0, 0, 0);                // Leaves r0 and r31 dirty
    loadRegister(tinkerPkg::STACK_REG, 36'($urandom()));
    emit(tinkerPkg::OP_STORE, 2, 1, 0, 'h100);          // r2 is still zero
    emit(tinkerPkg::OP_HLT, 0, 0, 0, 0);
  endfunction

  function automatic void resetStateProgram();
    progWords.delete();
    emit(tinkerPkg::OP_STORE, 0, 0, 0, 0);
    emit(tinkerPkg::OP_STORE, 0, tinkerPkg::STACK_REG, 0, 8);
    emit(tinkerPkg::OP_HLT, 0, 0, 0, 0);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // One test: reset, load, run to halt, compare
  ////////////////////////////////////////////////////////////////////////////
  task automatic runTest(string name);
    int loadCycles;
    int storesAtHalt;
    testErrors = 0;
    runModel();
    gotAddr.delete();
    gotData.delete();
    @(posedge clk);
    reset <= 1'b1;
    loadCycles = (progWords.size() > 16) ? progWords.size() : 16;  // 16 at least
    for (int i = 0; i < loadCycles; i++) begin
      @(posedge clk);
      progAddr <= tinkerPkg::RESET_PC + 64'(4 * i);
      if (i < progWords.size()) begin
        progWrite <= 1'b1;
        progData  <= progWords[i];
      end else begin
        progWrite <= 1'b0;
      end
    end
    @(posedge clk);
    progWrite <= 1'b0;
    reset     <= 1'b0;
    @(negedge clk);
    checkHalt(hlt, 1'b0);
    while (hlt !== 1'b1) @(negedge clk);             // Watchdog bounds this wait
    storesAtHalt = gotAddr.size();
    repeat (50) begin
      @(negedge clk);
      checkHalt(hlt, 1'b1);
    end
    if (gotAddr.size() != storesAtHalt) begin
      $display("Test %s: a store committed after the core halted", name);
      testErrors++;
    end
    if (gotAddr.size() != expAddr.size()) begin
      $display("Test %s: DUT committed %0d stores but the model expects %0d",
               name, gotAddr.size(), expAddr.size());
      testErrors++;
    end else begin
      foreach (expAddr[i]) checkStore(i, gotAddr[i], gotData[i], expAddr[i], expData[i]);
    end
    $display("Test %-10s %0d stores, %0d errors", name, gotAddr.size(), testErrors);
    errors += testErrors;
    if (testErrors != 0) failedTests++;
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    progWrite   = 1'b0;
    progAddr    = '0;
    progData    = '0;
    errors      = 0;
    failedTests = 0;
    void'($urandom(96));
    randomAluProgram(1'b0);
    runTest("alu");
    randomAluProgram(1'b1);
    runTest("immediate");
    memoryRoundTrip();
    runTest("loads");
    branchMix();
    runTest("branches");
    haltProgram();
    runTest("halt");
    resetStateProgram();
    runTest("resetState");
    $display("Tests %0d, failed tests %0d, failed checks %0d", NUM_TESTS, failedTests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Budget of 5 cycles per instruction for the longest allowed program
  initial begin
    #(NUM_TESTS * MAX_INSTRS * 5 * 10);
    $display("Timeout: the run did not finish within %0d ns", NUM_TESTS * MAX_INSTRS * 50);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+dv
rtl/tinkerPkg.sv
rtl/coreCtrlIf.sv
rtl/dataMemIf.sv
rtl/cycleControl.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/pcUnit.sv
rtl/byteMemory.sv
rtl/tinkerCore.sv
dv/tbTinkerCore.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator in timing mode, run, and scan the log for failure
verilator --binary --timing --assert --top-module tbTinkerCore -f filelist.f \
  && ./obj_dir/VtbTinkerCore > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
